// File: wb_host.f
common/wbh_pkg.sv
src/wbh_master_port.sv
wbh_reg/wbh_reg.sv
src/wbh_slave_port.sv
src/wb_host.sv
testbench/wb_host_assertions.sv
testbench/tb_wb_host.sv

// File: testbench/tb_wb_host.sv
// testbench for the wishbone host bridge, drives the master port, models the slave memory, compares
`timescale 1ns/1ps

module tb_wb_host;

    localparam int SEL_BIT   = 19;    // local decode bit
    localparam int WAIT_MAX  = 40;    // cycles per bus wait
    localparam int DRAIN_MAX = 20;

    // outcome of one master access, expected or observed
    typedef struct packed {
        logic              we;
        logic              loc;
        wbh_pkg::wb_data_t dat;
        logic              ack;
        logic              err;
        wbh_pkg::wb_addr_t xadr;    // outgoing address, 0 if no cycle
        logic [7:0]        ncyc;
        logic [7:0]        lat;     // edges after first sample
    } result_t;

    logic              wbm_clk;
    logic              s_reset_n;
    logic              wbm_cyc;
    logic              wbm_stb;
    wbh_pkg::wb_addr_t wbm_adr;
    logic              wbm_we;
    wbh_pkg::wb_data_t wbm_dat_w;
    wbh_pkg::wb_sel_t  wbm_sel;
    wbh_pkg::wb_data_t wbm_dat_r;
    logic              wbm_ack;
    logic              wbm_err;
    logic              wbs_cyc;
    logic              wbs_stb;
    wbh_pkg::wb_addr_t wbs_adr;
    logic              wbs_we;
    wbh_pkg::wb_data_t wbs_dat_w;
    wbh_pkg::wb_sel_t  wbs_sel;
    wbh_pkg::wb_data_t wbs_dat_r;
    logic              wbs_ack;
    logic              wbs_err;
    logic              int_rst_n;
    wbh_pkg::wb_data_t skew1;
    wbh_pkg::wb_data_t skew2;

    logic [31:0]       lfsr = 32'h2f3e;
    wbh_pkg::wb_data_t sh_reg [4];                  // shadow local regs
    wbh_pkg::wb_data_t sh_mem [logic [29:0]];       // shadow slave memory
    wbh_pkg::wb_data_t slv_mem [logic [29:0]];      // slave model storage
    int                slv_delay = 0;
    int                slv_wait = 0;
    logic              cyc_prev = 1'b0;
    int                cyc_count = 0;
    int                rsp_count = 0;
    wbh_pkg::wb_addr_t last_xadr = '0;
    result_t           exp_q [$];
    result_t           got_q [$];
    int                n_req = 0;
    int                n_fwd = 0;

    wb_host #(
        .LOCAL_SEL_BIT (SEL_BIT)
    ) dut0 (
        .wbm_clk_i            (wbm_clk),
        .s_reset_n            (s_reset_n),
        .wbm_cyc_i            (wbm_cyc),
        .wbm_stb_i            (wbm_stb),
        .wbm_adr_i            (wbm_adr),
        .wbm_we_i             (wbm_we),
        .wbm_dat_i            (wbm_dat_w),
        .wbm_sel_i            (wbm_sel),
        .wbm_dat_o            (wbm_dat_r),
        .wbm_ack_o            (wbm_ack),
        .wbm_err_o            (wbm_err),
        .wbs_cyc_o            (wbs_cyc),
        .wbs_stb_o            (wbs_stb),
        .wbs_adr_o            (wbs_adr),
        .wbs_we_o             (wbs_we),
        .wbs_dat_o            (wbs_dat_w),
        .wbs_sel_o            (wbs_sel),
        .wbs_dat_i            (wbs_dat_r),
        .wbs_ack_i            (wbs_ack),
        .wbs_err_i            (wbs_err),
        .wbd_int_rst_n_o      (int_rst_n),
        .cfg_clk_skew_ctrl1_o (skew1),
        .cfg_clk_skew_ctrl2_o (skew2)
    );

    initial begin
        wbm_clk = 1'b0;
        forever #20 wbm_clk = ~wbm_clk;    // 40 ns period
    end

    // ----------------------------------------
    // helpers and reference model
    // ----------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);    // galois, taps 32 22 2 1
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic wbh_pkg::wb_data_t merge_bytes(
        input wbh_pkg::wb_data_t old_val,
        input wbh_pkg::wb_data_t new_val,
        input wbh_pkg::wb_sel_t  sel
    );
        wbh_pkg::wb_data_t v;
        v = old_val;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) v[b*8 +: 8] = new_val[b*8 +: 8];
        end
        return v;
    endfunction

    // content of a never written word
    function automatic wbh_pkg::wb_data_t fill_word(input logic [29:0] waddr);
        return {waddr, 2'b10} ^ 32'h6b1d_c4a7;
    endfunction

    function automatic wbh_pkg::wb_addr_t local_adr(input logic [2:0] idx);
        logic [31:0] hi;
        hi = take_bits(12);
        return {hi[11:0], 1'b1, 14'h0, idx, 2'b00};
    endfunction

    function automatic wbh_pkg::wb_addr_t fwd_adr();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = take_bits(12);
        lo = take_bits(17);
        return {hi[11:0], 1'b0, lo[16:0], 2'b00};
    endfunction

    // expected result of one access, updates the shadow state
    function automatic result_t ref_access(
        input logic              we,
        input wbh_pkg::wb_addr_t adr,
        input wbh_pkg::wb_data_t dat,
        input wbh_pkg::wb_sel_t  sel
    );
        result_t           r;
        logic [2:0]        idx;
        logic [29:0]       waddr;
        wbh_pkg::wb_data_t cur;
        r     = '0;
        r.we  = we;
        r.loc = adr[SEL_BIT];
        if (r.loc) begin
            idx   = adr[4:2];
            r.ack = 1'b1;
            r.lat = 8'd3;
            if (idx < 3'd4) begin    // upper indices read zero
                r.dat = sh_reg[idx[1:0]];
                if (we) sh_reg[idx[1:0]] = merge_bytes(r.dat, dat, sel);
            end
            sh_reg[1] = sh_reg[1] & 32'h0000_ffff;    // bank select is 16 bits
        end else begin
            r.xadr = {sh_reg[1][15:3], adr[18:0]};
            r.ncyc = 8'd1;
            waddr  = r.xadr[31:2];
            if (&r.xadr[31:28]) begin
                r.err = 1'b1;
            end else begin
                r.ack = 1'b1;
                cur   = sh_mem.exists(waddr) ? sh_mem[waddr] : fill_word(waddr);
                if (we) sh_mem[waddr] = merge_bytes(cur, dat, sel);
                else    r.dat = cur;
            end
        end
        return r;
    endfunction

    task automatic stop_run(input string why);
        $display("error at %0t: %s", $time, why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            stop_run("stopping at the first mismatch");
        end
    endtask

    // one classic cycle on the master port, result goes to the compare queue
    task automatic bus_access(
        input logic              we,
        input wbh_pkg::wb_addr_t adr,
        input wbh_pkg::wb_data_t dat,
        input wbh_pkg::wb_sel_t  sel
    );
        result_t exp;
        result_t got;
        int      cnt;
        int      cyc_start;
        logic    done;
        exp       = ref_access(we, adr, dat, sel);
        slv_delay = int'(take_bits(2));    // 0 to 3 wait cycles
        @(posedge wbm_clk);
        cyc_start = cyc_count;
        wbm_cyc   <= 1'b1;
        wbm_stb   <= 1'b1;
        wbm_we    <= we;
        wbm_adr   <= adr;
        wbm_dat_w <= dat;
        wbm_sel   <= sel;
        cnt       = 0;
        done      = 1'b0;
        while (!done) begin
            @(posedge wbm_clk);
            cnt++;
            @(negedge wbm_clk);
            done = wbm_ack | wbm_err;
            if (!done && cnt >= WAIT_MAX) stop_run("no ack or err from the bridge in time");
        end
        got      = '0;
        got.we   = we;
        got.loc  = adr[SEL_BIT];
        got.dat  = wbm_dat_r;
        got.ack  = wbm_ack;
        got.err  = wbm_err;
        got.ncyc = 8'(cyc_count - cyc_start);
        got.xadr = (cyc_count != cyc_start) ? last_xadr : '0;
        got.lat  = 8'(cnt - 1);
        exp_q.push_back(exp);
        got_q.push_back(got);
        n_req++;
        if (!got.loc) n_fwd++;
        @(posedge wbm_clk);
        wbm_cyc <= 1'b0;    // at least one idle cycle follows
        wbm_stb <= 1'b0;
    endtask

    // ----------------------------------------
    // slave model and monitor
    // ----------------------------------------
    always @(posedge wbm_clk) begin : slave_model
        logic [29:0]       waddr;
        wbh_pkg::wb_data_t cur;
        if (!s_reset_n) begin
            wbs_ack   <= 1'b0;
            wbs_err   <= 1'b0;
            wbs_dat_r <= '0;
            slv_wait  <= 0;
        end else if (wbs_ack || wbs_err) begin
            wbs_ack <= 1'b0;    // bridge drops cyc on this edge
            wbs_err <= 1'b0;
        end else if (wbs_cyc && wbs_stb) begin
            if (slv_wait < slv_delay) begin
                slv_wait <= slv_wait + 1;
            end else begin
                slv_wait <= 0;
                waddr    = wbs_adr[31:2];
                if (&wbs_adr[31:28]) begin
                    wbs_err <= 1'b1;    // unmapped region
                end else begin
                    wbs_ack <= 1'b1;
                    cur     = slv_mem.exists(waddr) ? slv_mem[waddr] : fill_word(waddr);
                    if (wbs_we) begin
                        slv_mem[waddr] = merge_bytes(cur, wbs_dat_w, wbs_sel);
                        wbs_dat_r     <= '0;
                    end else begin
                        wbs_dat_r <= cur;
                    end
                end
            end
        end
    end

    always @(posedge wbm_clk) begin : bus_monitor
        cyc_prev <= wbs_cyc;
        if (wbs_cyc && !cyc_prev) cyc_count <= cyc_count + 1;
        if (wbs_cyc)              last_xadr <= wbs_adr;
        if (wbm_ack || wbm_err)   rsp_count <= rsp_count + 1;
    end

    always @(posedge wbm_clk) begin : compare_results
        result_t e;
        result_t g;
        while (got_q.size() > 0 && exp_q.size() > 0) begin
            e = exp_q.pop_front();
            g = got_q.pop_front();
            expect_equal("ack", g.ack, e.ack);
            expect_equal("err", g.err, e.err);
            expect_equal("outgoing cycles", g.ncyc, e.ncyc);
            expect_equal("slave address", g.xadr, e.xadr);
            if (e.loc)            expect_equal("local latency", g.lat, e.lat);
            if (!e.we && e.ack)   expect_equal("read data", g.dat, e.dat);
        end
    end

    // watch the bound protocol checker
    always @(posedge wbm_clk) begin : assertion_watch
        if (dut0.u_assertions.fail_cnt != 0) begin
            stop_run("a bound protocol assertion failed");
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin : stimulus
        wbh_pkg::wb_addr_t adr_list [6];
        logic [31:0]       rnd;
        logic [31:0]       dat;
        logic [31:0]       sel;
        logic [15:0]       bank;
        int                drain;
        s_reset_n = 1'b0;
        wbm_cyc   = 1'b0;
        wbm_stb   = 1'b0;
        wbm_adr   = '0;
        wbm_we    = 1'b0;
        wbm_dat_w = '0;
        wbm_sel   = '0;
        wbs_ack   = 1'b0;
        wbs_err   = 1'b0;
        wbs_dat_r = '0;
        sh_reg[0] = 32'h0;
        sh_reg[1] = 32'h0000_1000;    // bank select reset value
        sh_reg[2] = 32'h0;
        sh_reg[3] = 32'h0;
        repeat (16) @(posedge wbm_clk);
        s_reset_n <= 1'b1;

        // reset values, no outgoing cycle
        @(negedge wbm_clk);
        expect_equal("int reset after reset", int_rst_n, 1'b0);
        expect_equal("wbs_cyc_o after reset", wbs_cyc, 1'b0);
        for (int i = 0; i < 8; i++) begin
            bus_access(1'b0, local_adr(3'(i)), '0, 4'hf);
        end

        // byte-enabled writes to local regs, read back
        repeat (24) begin
            rnd = take_bits(3);
            dat = take_bits(32);
            sel = take_bits(4);
            bus_access(1'b1, local_adr(rnd[2:0]), dat, sel[3:0]);
            bus_access(1'b0, local_adr(rnd[2:0]), '0, 4'hf);
            expect_equal("skew ctrl1 output", skew1, sh_reg[2]);
            expect_equal("skew ctrl2 output", skew2, sh_reg[3]);
            expect_equal("int reset output", int_rst_n, sh_reg[0][0]);
        end

        // forwarded round trips under several banks
        repeat (4) begin
            rnd  = take_bits(16);
            bank = rnd[15:0];
            if (&bank[15:12]) bank[15] = 1'b0;    // keep out of the err region
            bus_access(1'b1, local_adr(3'd1), {16'h0, bank}, 4'b0011);
            for (int i = 0; i < 6; i++) begin
                adr_list[i] = fwd_adr();
                dat         = take_bits(32);
                sel         = take_bits(4);
                bus_access(1'b1, adr_list[i], dat, sel[3:0]);
            end
            for (int i = 0; i < 6; i++) begin
                bus_access(1'b0, adr_list[i], '0, 4'hf);
            end
        end

        // err region, then normal traffic again
        rnd = take_bits(12);
        bus_access(1'b1, local_adr(3'd1), {16'h0, 4'hf, rnd[11:0]}, 4'b0011);
        bus_access(1'b1, fwd_adr(), take_bits(32), 4'hf);
        bus_access(1'b0, fwd_adr(), '0, 4'hf);
        bus_access(1'b1, local_adr(3'd1), 32'h0000_1000, 4'b0011);
        adr_list[0] = fwd_adr();
        bus_access(1'b1, adr_list[0], take_bits(32), 4'hf);
        bus_access(1'b0, adr_list[0], '0, 4'hf);

        // mixed traffic, random slave delays
        repeat (30) begin
            rnd = take_bits(2);
            dat = take_bits(32);
            sel = take_bits(4);
            if (rnd[0]) bus_access(rnd[1], local_adr(3'(take_bits(3))), dat, sel[3:0]);
            else        bus_access(rnd[1], fwd_adr(), dat, sel[3:0]);
        end

        drain = 0;
        while (got_q.size() != 0) begin
            @(negedge wbm_clk);
            drain++;
            if (drain >= DRAIN_MAX) stop_run("compare queue did not drain");
        end
        @(negedge wbm_clk);
        expect_equal("outgoing cycle total", cyc_count, n_fwd);
        expect_equal("response total", rsp_count, n_req);
        if (dut0.u_assertions.fail_cnt == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            stop_run("a bound protocol assertion failed");
        end
    end

endmodule

// File: testbench/wb_host_assertions.sv
// concurrent protocol checks on the bridge top level, bound into wb_host by the bind below
`timescale 1ns/1ps

module wb_host_assertions (
    input logic              wbm_clk_i,
    input logic              s_reset_n,
    input logic              wbm_ack_o,
    input logic              wbm_err_o,
    input logic              wbs_stb_o,
    input wbh_pkg::wb_addr_t wbs_adr_o,
    input logic              wbs_ack_i,
    input logic              wbs_err_i
);

    int unsigned fail_cnt = 0;    // assertion failures so far

    // master side answers with ack or err, never both
    a_ack_err_excl: assert property (
        @(posedge wbm_clk_i) disable iff (!s_reset_n)
        !(wbm_ack_o && wbm_err_o)
    ) else begin
        $error("wbm_ack_o and wbm_err_o high in the same cycle");
        fail_cnt++;
    end

    // outgoing address held while the slave has not answered
    a_adr_stable: assert property (
        @(posedge wbm_clk_i) disable iff (!s_reset_n)
        (wbs_stb_o && !wbs_ack_i && !wbs_err_i) |=> $stable(wbs_adr_o)
    ) else begin
        $error("wbs_adr_o changed while wbs_stb_o waited for an answer");
        fail_cnt++;
    end

    a_ack_pulse: assert property (
        @(posedge wbm_clk_i) disable iff (!s_reset_n)
        wbm_ack_o |=> !wbm_ack_o
    ) else begin
        $error("wbm_ack_o high for more than one cycle");    // one ack per cycle
        fail_cnt++;
    end

endmodule

bind wb_host wb_host_assertions u_assertions (
    .wbm_clk_i (wbm_clk_i),
    .s_reset_n (s_reset_n),
    .wbm_ack_o (wbm_ack_o),
    .wbm_err_o (wbm_err_o),
    .wbs_stb_o (wbs_stb_o),
    .wbs_adr_o (wbs_adr_o),
    .wbs_ack_i (wbs_ack_i),
    .wbs_err_i (wbs_err_i)
);

// File: src/wb_host.sv
// top level of the wishbone host bridge, ties the master port, local regs and slave port together
`timescale 1ns/1ps

module wb_host #(
    parameter int LOCAL_SEL_BIT = wbh_pkg::LOCAL_SEL_BIT_DEF
) (
    input  logic              wbm_clk_i,
    input  logic              s_reset_n,

    // master side, wishbone classic
    input  logic              wbm_cyc_i,
    input  logic              wbm_stb_i,
    input  wbh_pkg::wb_addr_t wbm_adr_i,
    input  logic              wbm_we_i,
    input  wbh_pkg::wb_data_t wbm_dat_i,
    input  wbh_pkg::wb_sel_t  wbm_sel_i,
    output wbh_pkg::wb_data_t wbm_dat_o,
    output logic              wbm_ack_o,
    output logic              wbm_err_o,

    // slave side, same clock
    output logic              wbs_cyc_o,
    output logic              wbs_stb_o,
    output wbh_pkg::wb_addr_t wbs_adr_o,
    output logic              wbs_we_o,
    output wbh_pkg::wb_data_t wbs_dat_o,
    output wbh_pkg::wb_sel_t  wbs_sel_o,
    input  wbh_pkg::wb_data_t wbs_dat_i,
    input  logic              wbs_ack_i,
    input  logic              wbs_err_i,

    // config outputs from the local regs
    output logic              wbd_int_rst_n_o,
    output wbh_pkg::wb_data_t cfg_clk_skew_ctrl1_o,
    output wbh_pkg::wb_data_t cfg_clk_skew_ctrl2_o
);

    wbh_pkg::wb_req_t   req;        // registered request, shared
    logic               reg_req;    // local access pulse
    logic               ext_req;    // forwarded access pulse
    wbh_pkg::wb_rsp_t   reg_rsp;
    wbh_pkg::wb_rsp_t   ext_rsp;
    wbh_pkg::bank_sel_t bank_sel;
    wbh_pkg::wb_rsp_t   wbs_rsp;    // slave answer bundled

    assign wbs_rsp = '{dat: wbs_dat_i, ack: wbs_ack_i, err: wbs_err_i};

    // ----------------------------------------
    // input side
    // ----------------------------------------
    wbh_master_port #(
        .LOCAL_SEL_BIT (LOCAL_SEL_BIT)
    ) u_master (
        .wbm_clk_i (wbm_clk_i),
        .s_reset_n (s_reset_n),
        .wbm_cyc_i (wbm_cyc_i),
        .wbm_stb_i (wbm_stb_i),
        .wbm_adr_i (wbm_adr_i),
        .wbm_we_i  (wbm_we_i),
        .wbm_dat_i (wbm_dat_i),
        .wbm_sel_i (wbm_sel_i),
        .wbm_dat_o (wbm_dat_o),
        .wbm_ack_o (wbm_ack_o),
        .wbm_err_o (wbm_err_o),
        .reg_rsp_i (reg_rsp),
        .ext_rsp_i (ext_rsp),
        .req_o     (req),
        .reg_req_o (reg_req),
        .ext_req_o (ext_req)
    );

    // local control regs, bank select feeds the slave port
    wbh_reg u_reg (
        .wbm_clk_i            (wbm_clk_i),
        .s_reset_n            (s_reset_n),
        .reg_req_i            (reg_req),
        .req_i                (req),
        .reg_rsp_o            (reg_rsp),
        .bank_sel_o           (bank_sel),
        .wbd_int_rst_n_o      (wbd_int_rst_n_o),
        .cfg_clk_skew_ctrl1_o (cfg_clk_skew_ctrl1_o),
        .cfg_clk_skew_ctrl2_o (cfg_clk_skew_ctrl2_o)
    );

    // ----------------------------------------
    // output side
    // ----------------------------------------
    wbh_slave_port #(
        .LOCAL_SEL_BIT (LOCAL_SEL_BIT)
    ) u_slave (
        .wbm_clk_i  (wbm_clk_i),
        .s_reset_n  (s_reset_n),
        .ext_req_i  (ext_req),
        .req_i      (req),
        .bank_sel_i (bank_sel),
        .wbs_dat_i  (wbs_rsp.dat),
        .wbs_ack_i  (wbs_rsp.ack),
        .wbs_err_i  (wbs_rsp.err),
        .ext_rsp_o  (ext_rsp),
        .wbs_cyc_o  (wbs_cyc_o),
        .wbs_stb_o  (wbs_stb_o),
        .wbs_adr_o  (wbs_adr_o),
        .wbs_we_o   (wbs_we_o),
        .wbs_dat_o  (wbs_dat_o),
        .wbs_sel_o  (wbs_sel_o)
    );

endmodule

// File: src/wbh_slave_port.sv
// output stage of the host bridge, builds the banked address and runs the outgoing wishbone cycle
`timescale 1ns/1ps

module wbh_slave_port #(
    parameter int LOCAL_SEL_BIT = wbh_pkg::LOCAL_SEL_BIT_DEF
) (
    input  logic               wbm_clk_i,
    input  logic               s_reset_n,
    input  logic               ext_req_i,    // one-cycle launch pulse
    input  wbh_pkg::wb_req_t   req_i,
    input  wbh_pkg::bank_sel_t bank_sel_i,
    input  wbh_pkg::wb_data_t  wbs_dat_i,
    input  logic               wbs_ack_i,
    input  logic               wbs_err_i,
    output wbh_pkg::wb_rsp_t   ext_rsp_o,
    output logic               wbs_cyc_o,
    output logic               wbs_stb_o,
    output wbh_pkg::wb_addr_t  wbs_adr_o,
    output logic               wbs_we_o,
    output wbh_pkg::wb_data_t  wbs_dat_o,
    output wbh_pkg::wb_sel_t   wbs_sel_o
);

    // mask for the pass-through address bits below the decode bit
    localparam wbh_pkg::wb_addr_t LOW_MASK =
        (wbh_pkg::wb_addr_t'(1) << LOCAL_SEL_BIT) - wbh_pkg::wb_addr_t'(1);

    wbh_pkg::slv_state_e state;
    wbh_pkg::wb_addr_t   ext_adr;      // bank joined to low address
    logic                launch;
    logic                done;         // slave answered this cycle
    logic                cyc_q;
    wbh_pkg::wb_addr_t   adr_q;
    logic                we_q;
    wbh_pkg::wb_data_t   dat_q;
    wbh_pkg::wb_sel_t    sel_q;
    logic                rsp_ack_q;
    logic                rsp_err_q;
    wbh_pkg::wb_data_t   rsp_dat_q;

    // bank bits 15:BANK_LSB go on top, request bits below the decode bit underneath
    assign ext_adr = ((wbh_pkg::wb_addr_t'(bank_sel_i) >> wbh_pkg::BANK_LSB) << LOCAL_SEL_BIT)
                   | (req_i.adr & LOW_MASK);

    assign launch = (state == wbh_pkg::SLV_IDLE) & ext_req_i;
    assign done   = (state == wbh_pkg::SLV_BUSY) & (wbs_ack_i | wbs_err_i);

    // ----------------------------------------
    // cycle fsm
    // ----------------------------------------
    always_ff @(posedge wbm_clk_i) begin
        if (!s_reset_n) begin
            state     <= wbh_pkg::SLV_IDLE;
            cyc_q     <= 1'b0;
            rsp_ack_q <= 1'b0;
            rsp_err_q <= 1'b0;
        end else begin
            rsp_ack_q <= 1'b0;    // response is a single pulse
            rsp_err_q <= 1'b0;
            case (state)
                wbh_pkg::SLV_IDLE: begin
                    if (launch) begin
                        cyc_q <= 1'b1;
                        state <= wbh_pkg::SLV_BUSY;
                    end
                end
                wbh_pkg::SLV_BUSY: begin
                    if (done) begin                            // drop cyc on the answer edge
                        cyc_q     <= 1'b0;
                        rsp_ack_q <= wbs_ack_i & ~wbs_err_i;   // err wins
                        rsp_err_q <= wbs_err_i;
                        state     <= wbh_pkg::SLV_DONE;
                    end
                end
                wbh_pkg::SLV_DONE: begin
                    state <= wbh_pkg::SLV_IDLE;   // response on the port this cycle
                end
                default: begin
                    cyc_q <= 1'b0;
                    state <= wbh_pkg::SLV_IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------
    // outgoing payload and read data
    // ----------------------------------------
    always_ff @(posedge wbm_clk_i) begin
        if (launch) begin
            adr_q <= ext_adr;     // held for the whole cycle
            we_q  <= req_i.we;
            dat_q <= req_i.dat;
            sel_q <= req_i.sel;
        end
        if (done) begin
            rsp_dat_q <= wbs_dat_i;
        end
    end

    assign wbs_cyc_o = cyc_q;
    assign wbs_stb_o = cyc_q;     // classic, one beat per cycle
    assign wbs_adr_o = adr_q;
    assign wbs_we_o  = we_q;
    assign wbs_dat_o = dat_q;
    assign wbs_sel_o = sel_q;

    assign ext_rsp_o = '{dat: rsp_dat_q, ack: rsp_ack_q, err: rsp_err_q};

endmodule

// File: wbh_reg/wbh_reg.sv
// local control and status registers of the host bridge, byte-enabled writes, fixed one-cycle ack
`timescale 1ns/1ps

module wbh_reg (
    input  logic               wbm_clk_i,
    input  logic               s_reset_n,
    input  logic               reg_req_i,     // one-cycle access pulse
    input  wbh_pkg::wb_req_t   req_i,
    output wbh_pkg::wb_rsp_t   reg_rsp_o,
    output wbh_pkg::bank_sel_t bank_sel_o,
    output logic               wbd_int_rst_n_o,
    output wbh_pkg::wb_data_t  cfg_clk_skew_ctrl1_o,
    output wbh_pkg::wb_data_t  cfg_clk_skew_ctrl2_o
);

    wbh_pkg::reg_idx_t  reg_idx;
    logic               wr_en;
    wbh_pkg::wb_data_t  glbl_ctrl;     // bit 0 is the internal reset
    wbh_pkg::bank_sel_t bank_sel;
    wbh_pkg::wb_data_t  skew_ctrl1;
    wbh_pkg::wb_data_t  skew_ctrl2;
    wbh_pkg::wb_data_t  rd_data;
    wbh_pkg::wb_data_t  rsp_dat_q;
    logic               rsp_ack_q;

    // merge write data into the old value per byte lane
    function automatic wbh_pkg::wb_data_t be_merge(
        input wbh_pkg::wb_data_t cur,
        input wbh_pkg::wb_data_t wdata,
        input wbh_pkg::wb_sel_t  sel
    );
        wbh_pkg::wb_data_t res;
        res = cur;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                res[i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
        return res;
    endfunction

    assign reg_idx = req_i.adr[4:2];
    assign wr_en   = reg_req_i & req_i.we;

    // ----------------------------------------
    // register file
    // ----------------------------------------
    always_ff @(posedge wbm_clk_i) begin
        if (!s_reset_n) begin
            glbl_ctrl  <= '0;
            bank_sel   <= wbh_pkg::BANK_SEL_RST;
            skew_ctrl1 <= '0;
            skew_ctrl2 <= '0;
        end else if (wr_en) begin
            case (reg_idx)
                wbh_pkg::REG_GLBL_CTRL: begin
                    glbl_ctrl <= be_merge(glbl_ctrl, req_i.dat, req_i.sel);
                end
                wbh_pkg::REG_BANK_SEL: begin     // only the lower two lanes exist
                    bank_sel <= wbh_pkg::bank_sel_t'(be_merge(
                        wbh_pkg::wb_data_t'(bank_sel), req_i.dat, req_i.sel));
                end
                wbh_pkg::REG_SKEW_CTRL1: begin
                    skew_ctrl1 <= be_merge(skew_ctrl1, req_i.dat, req_i.sel);
                end
                wbh_pkg::REG_SKEW_CTRL2: begin
                    skew_ctrl2 <= be_merge(skew_ctrl2, req_i.dat, req_i.sel);
                end
                default: begin
                    // unused index, write dropped
                end
            endcase
        end
    end

    // read mux, holes read zero
    always_comb begin
        case (reg_idx)
            wbh_pkg::REG_GLBL_CTRL:  rd_data = glbl_ctrl;
            wbh_pkg::REG_BANK_SEL:   rd_data = wbh_pkg::wb_data_t'(bank_sel);
            wbh_pkg::REG_SKEW_CTRL1: rd_data = skew_ctrl1;
            wbh_pkg::REG_SKEW_CTRL2: rd_data = skew_ctrl2;
            default:                 rd_data = '0;
        endcase
    end

    // ----------------------------------------
    // response, one cycle after the request
    // ----------------------------------------
    always_ff @(posedge wbm_clk_i) begin
        if (!s_reset_n) begin
            rsp_ack_q <= 1'b0;
        end else begin
            rsp_ack_q <= reg_req_i;
        end
    end

    always_ff @(posedge wbm_clk_i) begin
        if (reg_req_i) begin
            rsp_dat_q <= rd_data;    // value before any write in this cycle
        end
    end

    assign reg_rsp_o = '{dat: rsp_dat_q, ack: rsp_ack_q, err: 1'b0};

    assign bank_sel_o           = bank_sel;
    assign wbd_int_rst_n_o      = glbl_ctrl[0];
    assign cfg_clk_skew_ctrl1_o = skew_ctrl1;
    assign cfg_clk_skew_ctrl2_o = skew_ctrl2;

endmodule

// File: src/wbh_master_port.sv
// input stage of the host bridge, registers master requests, decodes them and returns responses
`timescale 1ns/1ps

module wbh_master_port #(
    parameter int LOCAL_SEL_BIT = wbh_pkg::LOCAL_SEL_BIT_DEF
) (
    input  logic              wbm_clk_i,
    input  logic              s_reset_n,
    input  logic              wbm_cyc_i,
    input  logic              wbm_stb_i,
    input  wbh_pkg::wb_addr_t wbm_adr_i,
    input  logic              wbm_we_i,
    input  wbh_pkg::wb_data_t wbm_dat_i,
    input  wbh_pkg::wb_sel_t  wbm_sel_i,
    output wbh_pkg::wb_data_t wbm_dat_o,
    output logic              wbm_ack_o,
    output logic              wbm_err_o,
    input  wbh_pkg::wb_rsp_t  reg_rsp_i,   // local reg answer
    input  wbh_pkg::wb_rsp_t  ext_rsp_i,   // slave port answer
    output wbh_pkg::wb_req_t  req_o,
    output logic              reg_req_o,
    output logic              ext_req_o
);

    logic              stb_in;        // cyc qualified strobe
    logic              rsp_busy;      // ack/err in flight, block repeats
    logic              req_pending;
    logic              pending_d;
    logic              req_pulse;     // one per master cycle
    logic              is_local;
    logic              rsp_ack;
    logic              rsp_err;
    wbh_pkg::wb_data_t rsp_dat;
    wbh_pkg::wb_req_t  req_q;

    assign stb_in   = wbm_cyc_i & wbm_stb_i;
    assign rsp_busy = wbm_ack_o | wbm_err_o | rsp_ack | rsp_err;

    // ----------------------------------------
    // request capture
    // ----------------------------------------
    always_ff @(posedge wbm_clk_i) begin
        if (stb_in && !rsp_busy) begin    // master holds these until ack
            req_q.we  <= wbm_we_i;
            req_q.adr <= wbm_adr_i;
            req_q.dat <= wbm_dat_i;
            req_q.sel <= wbm_sel_i;
        end
    end

    assign req_o = req_q;

    // decode once, on the registered address
    assign is_local  = req_q.adr[LOCAL_SEL_BIT];
    assign reg_req_o = req_pulse & is_local;
    assign ext_req_o = req_pulse & ~is_local;

    // pick the answering side, local regs never err
    assign rsp_ack = is_local ? reg_rsp_i.ack : ext_rsp_i.ack;
    assign rsp_err = is_local ? 1'b0          : ext_rsp_i.err;
    assign rsp_dat = is_local ? reg_rsp_i.dat : ext_rsp_i.dat;

    // ----------------------------------------
    // control and response registers
    // ----------------------------------------
    always_ff @(posedge wbm_clk_i) begin
        if (!s_reset_n) begin
            req_pending <= 1'b0;
            pending_d   <= 1'b0;
            req_pulse   <= 1'b0;
            wbm_ack_o   <= 1'b0;
            wbm_err_o   <= 1'b0;
            wbm_dat_o   <= '0;
        end else begin
            req_pending <= stb_in & ~rsp_busy;       // drops once the answer is back
            pending_d   <= req_pending;
            req_pulse   <= req_pending & ~pending_d; // rising edge only
            wbm_ack_o   <= rsp_ack;
            wbm_err_o   <= rsp_err;
            if (rsp_ack) begin
                wbm_dat_o <= rsp_dat;                // last read data stays on the bus
            end
        end
    end

endmodule

// File: common/wbh_pkg.sv
// shared widths, request and response structs and register map for the wishbone host bridge
package wbh_pkg;

    // ----------------------------------------
    // bus widths
    // ----------------------------------------
    typedef logic [31:0] wb_addr_t;    // byte address
    typedef logic [31:0] wb_data_t;    // data word
    typedef logic [3:0]  wb_sel_t;     // byte enables
    typedef logic [15:0] bank_sel_t;   // upper address bank
    typedef logic [2:0]  reg_idx_t;    // local reg index, adr[4:2]

    // registered request from the input side, 69 bits
    typedef struct packed {
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
        wb_sel_t  sel;
    } wb_req_t;

    // response back to the input side, 34 bits
    typedef struct packed {
        wb_data_t dat;
        logic     ack;
        logic     err;
    } wb_rsp_t;

    // outgoing cycle fsm
    typedef enum logic [1:0] {
        SLV_IDLE,
        SLV_BUSY,
        SLV_DONE    // response pulse cycle
    } slv_state_e;

    // ----------------------------------------
    // address map
    // ----------------------------------------
    localparam int LOCAL_SEL_BIT_DEF = 19;   // adr bit that picks the local regs
    localparam int BANK_LSB          = 3;    // bank bits 15:3 form the upper address

    localparam reg_idx_t REG_GLBL_CTRL  = 3'd0;
    localparam reg_idx_t REG_BANK_SEL   = 3'd1;
    localparam reg_idx_t REG_SKEW_CTRL1 = 3'd2;
    localparam reg_idx_t REG_SKEW_CTRL2 = 3'd3;

    localparam bank_sel_t BANK_SEL_RST = 16'h1000;

endpackage
